//--- filelist.f
+incdir+include
rtl/isaPkg.sv
rtl/datapathPkg.sv
rtl/instrQueue.sv
rtl/registerFile.sv
rtl/busEncoder.sv
rtl/alu.sv
rtl/datapath.sv
rtl/controlSequencer.sv
rtl/busCpuTop.sv
verif/busCpu_props.sv
verif/busCpuTb.sv

//--- Makefile
# Verilator build and run of the bus CPU testbench.

VERILATOR ?= verilator
TOP       ?= busCpuTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/busCpuTb.sv
`timescale 1ns/1ps
`include "busCpu_config.svh"

module busCpuTb;
        import isaPkg::*;
        import datapathPkg::*;

        localparam int queueDepth = `BUSCPU_QUEUE_DEPTH;
        localparam int resultCredits = `BUSCPU_RESULT_CREDITS;
        localparam int totalWords = 64;
        localparam int cycleLimit = 8 * totalWords * 6 + 200;
        localparam int stallLimit = 150;        // Longer than the 100 cycle credit hold.
        localparam int drainLimit = 200;

        logic      Clock;
        logic      rstN;
        logic      instrValid;
        instrWordT instrWord;
        logic      resCredit;
        logic      instrCredit;
        logic      resValid;
        resultT    resData;

        integer      seed = 32'h813356f2;
        logic [31:0] modelRegs [16];
        int          fetchCount = 0;
        resultT      expQ [$];
        int          wordsSent = 0;
        int          creditsIn = 0;
        int          resultsSeen = 0;
        int          creditsOut = 0;
        int          cycleCount = 0;
        int          stallCycles = 0;
        bit          creditHold = 1'b0;
        int          creditEvery = 1;
        logic [4:0]  opChoices [10] = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opMul, opAddi,
                                        5'b00000, 5'b11111};

        busCpuTop dut (
                .Clock       (Clock),
                .rstN        (rstN),
                .instrValid  (instrValid),
                .instrWord   (instrWord),
                .resCredit   (resCredit),
                .instrCredit (instrCredit),
                .resValid    (resValid),
                .resData     (resData)
        );

        initial begin
                Clock = 1'b0;
                forever #5 Clock = ~Clock;
        end

        task automatic abortRun(input string reason);
                $display("%s", reason);
                $display("TB FAILED");
                $fatal(1, "Simulation stopped.");
        endtask

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (expected !== actual) begin
                        abortRun($sformatf("FAILED at %0t: %s expected %h, got %h",
                                           $time, name, expected, actual));
                end
        endtask

        function automatic logic [31:0] rWord(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [3:0] rc);
                return {op, ra, rb, rc, 15'd0};
        endfunction

        function automatic logic [31:0] iWord(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [18:0] imm);
                return {op, ra, rb, imm};
        endfunction

        function automatic logic [31:0] randomWord();
                logic [31:0] w;
                int          pick;
                w = $random(seed);
                pick = int'({$random(seed)} % 10);
                w[31:27] = opChoices[pick];     // Mostly legal opcodes, two illegal ones.
                return w;
        endfunction

        // Applies one word to the model registers; returns 1 when a record is expected.
        function automatic bit refExecute(input logic [31:0] word, output resultT rec);
                logic [3:0]  ra;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] v;
                bit          legal;
                ra = word[26:23];
                a = (word[22:19] == 4'd0) ? 32'd0 : modelRegs[word[22:19]];
                b = (word[18:15] == 4'd0) ? 32'd0 : modelRegs[word[18:15]];
                legal = 1'b1;
                case (word[31:27])
                        opAdd:   v = a + b;
                        opSub:   v = a - b;
                        opAnd:   v = a & b;
                        opOr:    v = a | b;
                        opShl:   v = a << b[4:0];
                        opShr:   v = a >> b[4:0];
                        opMul:   v = a * b;
                        opAddi:  v = a + {{13{word[18]}}, word[18:0]};
                        default: begin
                                legal = 1'b0;
                                v = 32'd0;
                        end
                endcase
                rec.dest = ra;
                rec.value = v;
                rec.seq = 4'(fetchCount);       // Every fetched word advances the PC.
                fetchCount++;
                if (legal && ra != 4'd0) begin
                        modelRegs[ra] = v;
                end
                return legal;
        endfunction

        task automatic sendWord(input logic [31:0] word);
                resultT rec;
                while (queueDepth + creditsIn - wordsSent == 0) begin
                        instrValid = 1'b0;
                        @(posedge Clock);
                        #1;
                end
                instrValid = 1'b1;
                instrWord = word;
                wordsSent++;
                if (refExecute(word, rec)) begin
                        expQ.push_back(rec);
                end
                @(posedge Clock);
                #1;
        endtask

        task automatic waitDrain();
                int waited;
                instrValid = 1'b0;
                waited = 0;
                while ((resultsSeen != expQ.size() || creditsOut != resultsSeen ||
                        creditsIn != wordsSent) && waited < drainLimit) begin
                        @(posedge Clock);
                        #1;
                        waited++;
                end
                checkValue("producerCredits", 32'(queueDepth),
                           32'(queueDepth + creditsIn - wordsSent));
        endtask

        initial begin : creditReturn
                resCredit = 1'b0;
                forever begin
                        @(posedge Clock);
                        #1;
                        if (!creditHold && resultsSeen > creditsOut &&
                            cycleCount % creditEvery == 0) begin
                                resCredit = 1'b1;
                                creditsOut++;
                        end else begin
                                resCredit = 1'b0;
                        end
                end
        end

        // Outputs are compared at the falling edge, half a cycle away from any update.
        always @(negedge Clock) begin
                if (rstN) begin
                        if (instrCredit) begin
                                creditsIn++;
                        end
                        if (creditsIn > wordsSent) begin
                                abortRun("More instruction credits returned than words sent.");
                        end
                        if (resValid && resultsSeen >= expQ.size()) begin
                                abortRun("Unexpected result with no instruction pending.");
                        end else if (resValid) begin
                                checkValue("resData.dest", 32'(expQ[resultsSeen].dest),
                                           32'(resData.dest));
                                checkValue("resData.value", expQ[resultsSeen].value,
                                           resData.value);
                                checkValue("resData.seq", 32'(expQ[resultsSeen].seq),
                                           32'(resData.seq));
                                resultsSeen++;
                                stallCycles = 0;
                        end else if (resultsSeen < expQ.size()) begin
                                stallCycles++;
                                if (stallCycles > stallLimit) begin
                                        abortRun("Expected results stopped arriving.");
                                end
                        end
                end
        end

        always @(posedge Clock) begin
                cycleCount++;
                if (cycleCount > cycleLimit) begin
                        abortRun("Timeout: the run took longer than its cycle limit.");
                end
        end

        initial begin : stimulus
                int heldStart;
                rstN = 1'b0;
                instrValid = 1'b0;
                instrWord = '0;
                for (int r = 0; r < 16; r++) begin
                        modelRegs[r] = 32'd0;
                end
                repeat (4) @(posedge Clock);
                #1;
                rstN = 1'b1;

                creditEvery = 3;        // Slow consumer for the directed words.
                sendWord(iWord(opAddi, 4'd1, 4'd0, 19'd1234));
                sendWord(iWord(opAddi, 4'd2, 4'd0, 19'd77));
                sendWord(iWord(opAddi, 4'd3, 4'd0, 19'd5));
                sendWord(rWord(opAdd, 4'd4, 4'd1, 4'd2));
                sendWord(rWord(opSub, 4'd5, 4'd2, 4'd1));
                sendWord(rWord(opAnd, 4'd6, 4'd1, 4'd2));
                sendWord(rWord(opOr, 4'd7, 4'd1, 4'd2));
                sendWord(rWord(opShl, 4'd8, 4'd1, 4'd3));
                sendWord(rWord(opShr, 4'd9, 4'd1, 4'd3));
                sendWord(rWord(opMul, 4'd10, 4'd1, 4'd2));
                sendWord(iWord(opAddi, 4'd11, 4'd0, 19'h7fff9));        // Minus 7.
                sendWord(iWord(opAddi, 4'd12, 4'd11, 19'h7fc18));       // Minus 1000.
                sendWord(iWord(opAddi, 4'd0, 4'd1, 19'd5));
                sendWord(rWord(opAdd, 4'd13, 4'd0, 4'd0));
                sendWord(rWord(opOr, 4'd14, 4'd0, 4'd2));
                sendWord(rWord(5'b11111, 4'd15, 4'd1, 4'd2));
                sendWord(rWord(opAdd, 4'd15, 4'd1, 4'd2));
                sendWord(rWord(5'b00000, 4'd15, 4'd1, 4'd2));
                sendWord(rWord(opSub, 4'd15, 4'd15, 4'd1));
                waitDrain();

                creditEvery = 1;
                repeat (40) sendWord(randomWord());
                waitDrain();

                repeat (2) @(posedge Clock);
                #1;
                creditHold = 1'b1;
                heldStart = resultsSeen;
                for (int i = 0; i < 5; i++) begin
                        sendWord(iWord(opAddi, 4'(i + 1), 4'(i), 19'(i * 3)));
                end
                instrValid = 1'b0;
                repeat (100) @(posedge Clock);
                #1;
                checkValue("resultsWhileHeld", 32'(resultCredits),
                           32'(resultsSeen - heldStart));
                creditHold = 1'b0;
                waitDrain();

                $display("TB PASSED");
                $finish;
        end

endmodule

//--- verif/busCpu_props.sv
`timescale 1ns/1ps
`include "busCpu_config.svh"

module busCpuProps (
        input logic                                          Clock,
        input logic                                          rstN,
        input datapathPkg::ctrlWordT                         ctrl,
        input logic                                          resValid,
        input logic [$clog2(`BUSCPU_RESULT_CREDITS + 1)-1:0] creditCount,
        input logic [$clog2(`BUSCPU_QUEUE_DEPTH + 1)-1:0]    queueCount
);

        busOneDriver: assert property (@(posedge Clock) disable iff (!rstN)
                $onehot0({ctrl.regOut, ctrl.pcOut, ctrl.mdrOut, ctrl.zOut, ctrl.immOut}))
                else $error("More than one unit drives the bus.");

        resultPulse: assert property (@(posedge Clock) disable iff (!rstN)
                resValid |=> !resValid)
                else $error("resValid stayed high for more than one cycle.");

        // A record may only leave while the consumer still has room.
        creditFloor: assert property (@(posedge Clock) disable iff (!rstN)
                resValid |-> creditCount != '0)
                else $error("Result credit counter would underflow.");

        queueBound: assert property (@(posedge Clock) disable iff (!rstN)
                queueCount <= `BUSCPU_QUEUE_DEPTH)
                else $error("Instruction queue holds more words than its depth.");

endmodule

bind controlSequencer busCpuProps seqProps (
        .Clock       (Clock),
        .rstN        (rstN),
        .ctrl        (ctrl),
        .resValid    (resValid),
        .creditCount (creditCount),
        .queueCount  ('0)
);

bind instrQueue busCpuProps queueProps (
        .Clock       (Clock),
        .rstN        (rstN),
        .ctrl        ('0),
        .resValid    (1'b0),
        .creditCount ('0),
        .queueCount  (count)
);

//--- rtl/busCpuTop.sv
`timescale 1ns/1ps

module busCpuTop (
        input  logic                Clock,
        input  logic                rstN,
        input  logic                instrValid,
        input  isaPkg::instrWordT   instrWord,
        input  logic                resCredit,
        output logic                instrCredit,
        output logic                resValid,
        output datapathPkg::resultT resData
);
        import isaPkg::*;
        import datapathPkg::*;

        logic        queueEmpty;
        logic        pop;
        instrWordT   headWord;
        instrWordT   fetchWord;
        instrWordT   ir;
        ctrlWordT    ctrl;
        logic [31:0] zValue;
        logic [31:0] pc;

        instrQueue queue (
                .Clock       (Clock),
                .rstN        (rstN),
                .instrValid  (instrValid),
                .instrWord   (instrWord),
                .pop         (pop),
                .queueEmpty  (queueEmpty),
                .headWord    (headWord),
                .instrCredit (instrCredit)
        );

        controlSequencer sequencer (
                .Clock      (Clock),
                .rstN       (rstN),
                .queueEmpty (queueEmpty),
                .headWord   (headWord),
                .ir         (ir),
                .zValue     (zValue),
                .pc         (pc),
                .resCredit  (resCredit),
                .pop        (pop),
                .fetchWord  (fetchWord),
                .ctrl       (ctrl),
                .resValid   (resValid),
                .resData    (resData)
        );

        datapath dp (
                .Clock     (Clock),
                .rstN      (rstN),
                .ctrl      (ctrl),
                .fetchWord (fetchWord),
                .ir        (ir),
                .zValue    (zValue),
                .pc        (pc)
        );

endmodule

//--- rtl/controlSequencer.sv
`timescale 1ns/1ps
`include "busCpu_config.svh"

module controlSequencer (
        input  logic                  Clock,
        input  logic                  rstN,
        input  logic                  queueEmpty,
        input  isaPkg::instrWordT     headWord,
        input  isaPkg::instrWordT     ir,
        input  logic [31:0]           zValue,
        input  logic [31:0]           pc,
        input  logic                  resCredit,
        output logic                  pop,
        output isaPkg::instrWordT     fetchWord,
        output datapathPkg::ctrlWordT ctrl,
        output logic                  resValid,
        output datapathPkg::resultT   resData
);
        import isaPkg::*;

        localparam int creditWidth = $clog2(`BUSCPU_RESULT_CREDITS + 1);

        typedef enum logic [2:0] {
                stepIdle,
                stepT1,
                stepT2,
                stepT3,
                stepT4,
                stepT5
        } stepT;

        stepT                   step;
        stepT                   nextStep;
        logic [creditWidth-1:0] creditCount;
        logic [3:0]             seqReg;
        opcodeT                 opcode;
        logic                   start;

        assign opcode = ir.rFmt.opcode;
        assign start = !queueEmpty && (creditCount != '0);

        // The head word is read during T1 and leaves the queue at the end of it.
        assign pop = (step == stepT1);
        assign fetchWord = headWord;

        assign resValid = (step == stepT5);
        assign resData.dest = ir.rFmt.ra;
        assign resData.value = zValue;
        assign resData.seq = seqReg;

        always_comb begin
                nextStep = step;
                case (step)
                        stepIdle: nextStep = start ? stepT1 : stepIdle;
                        stepT1:   nextStep = stepT2;
                        stepT2:   nextStep = stepT3;
                        stepT3:   nextStep = isLegalOp(opcode) ? stepT4 : stepIdle;
                        stepT4:   nextStep = stepT5;
                        default:  nextStep = stepIdle;
                endcase
        end

        always_comb begin
                ctrl = '0;
                ctrl.aluOp = opcode;
                case (step)
                        stepT1: begin
                                ctrl.mdrIn = 1'b1;
                                ctrl.pcInc = 1'b1;
                        end
                        stepT2: begin
                                ctrl.mdrOut = 1'b1;
                                ctrl.irIn = 1'b1;
                        end
                        stepT3: begin
                                if (isLegalOp(opcode)) begin
                                        ctrl.regOut = 1'b1;
                                        ctrl.regSel = ir.rFmt.rb;
                                        ctrl.yIn = 1'b1;
                                end
                        end
                        stepT4: begin
                                if (opcode == opAddi) begin
                                        ctrl.immOut = 1'b1;
                                end else begin
                                        ctrl.regOut = 1'b1;
                                        ctrl.regSel = ir.rFmt.rc;
                                end
                                ctrl.zIn = 1'b1;
                        end
                        stepT5: begin
                                ctrl.zOut = 1'b1;
                                ctrl.regIn = 1'b1;
                                ctrl.regSel = ir.rFmt.ra;
                        end
                        default: ;
                endcase
        end

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        step <= stepIdle;
                        creditCount <= creditWidth'(`BUSCPU_RESULT_CREDITS);
                        seqReg <= 4'd0;
                end else begin
                        step <= nextStep;
                        if (step == stepT1) begin
                                seqReg <= pc[3:0];      // PC still holds this word's address.
                        end
                        case ({resCredit, resValid})
                                2'b10: creditCount <= creditCount + 1'b1;
                                2'b01: creditCount <= creditCount - 1'b1;
                                default: creditCount <= creditCount;
                        endcase
                end
        end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath (
        input  logic                  Clock,
        input  logic                  rstN,
        input  datapathPkg::ctrlWordT ctrl,
        input  isaPkg::instrWordT     fetchWord,
        output isaPkg::instrWordT     ir,
        output logic [31:0]           zValue,
        output logic [31:0]           pc
);
        import datapathPkg::*;

        busSrcT      busSrc;
        logic [31:0] bus;
        logic [31:0] regData;
        logic [31:0] mdr;
        logic [31:0] yReg;
        logic [31:0] aluResult;
        logic [31:0] immValue;

        assign immValue = {{13{ir.iFmt.imm[18]}}, ir.iFmt.imm};

        registerFile regFile (
                .Clock   (Clock),
                .rstN    (rstN),
                .regSel  (ctrl.regSel),
                .regIn   (ctrl.regIn),
                .busIn   (bus),
                .regData (regData)
        );

        busEncoder encoder (
                .ctrl     (ctrl),
                .regData  (regData),
                .pcValue  (pc),
                .mdrValue (mdr),
                .zValue   (zValue),
                .immValue (immValue),
                .busSrc   (busSrc),
                .bus      (bus)
        );

        alu aluUnit (
                .op     (ctrl.aluOp),
                .a      (yReg),
                .b      (bus),
                .result (aluResult)
        );

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        pc <= 32'd0;
                        ir <= '0;
                end else begin
                        if (ctrl.pcInc) begin
                                pc <= pc + 32'd1;       // One word per instruction.
                        end
                        if (ctrl.irIn) begin
                                ir <= bus;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                // MDR takes the fetched word unless something drives the bus.
                if (ctrl.mdrIn) begin
                        mdr <= (busSrc == srcNone) ? fetchWord : bus;
                end
                if (ctrl.yIn) begin
                        yReg <= bus;
                end
                if (ctrl.zIn) begin
                        zValue <= aluResult;
                end
        end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
        input  isaPkg::opcodeT op,
        input  logic [31:0]    a,
        input  logic [31:0]    b,
        output logic [31:0]    result
);
        import isaPkg::*;

        always_comb begin
                case (op)
                        opAdd, opAddi: result = a + b;
                        opSub:         result = a - b;
                        opAnd:         result = a & b;
                        opOr:          result = a | b;
                        opShl:         result = a << b[4:0];
                        opShr:         result = a >> b[4:0];   // Logical shift.
                        opMul:         result = a * b;         // Low half of the product.
                        default:       result = 32'd0;
                endcase
        end

endmodule

//--- rtl/busEncoder.sv
`timescale 1ns/1ps

module busEncoder (
        input  datapathPkg::ctrlWordT ctrl,
        input  logic [31:0]           regData,
        input  logic [31:0]           pcValue,
        input  logic [31:0]           mdrValue,
        input  logic [31:0]           zValue,
        input  logic [31:0]           immValue,
        output datapathPkg::busSrcT   busSrc,
        output logic [31:0]           bus
);
        import datapathPkg::*;

        always_comb begin
                if (ctrl.regOut) begin
                        busSrc = srcReg;
                end else if (ctrl.pcOut) begin
                        busSrc = srcPc;
                end else if (ctrl.mdrOut) begin
                        busSrc = srcMdr;
                end else if (ctrl.zOut) begin
                        busSrc = srcZ;
                end else if (ctrl.immOut) begin
                        busSrc = srcImm;
                end else begin
                        busSrc = srcNone;
                end
        end

        always_comb begin
                case (busSrc)
                        srcReg:  bus = regData;
                        srcPc:   bus = pcValue;
                        srcMdr:  bus = mdrValue;
                        srcZ:    bus = zValue;
                        srcImm:  bus = immValue;
                        default: bus = 32'd0;   // Undriven bus reads as zero.
                endcase
        end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
        input  logic        Clock,
        input  logic        rstN,
        input  logic [3:0]  regSel,
        input  logic        regIn,
        input  logic [31:0] busIn,
        output logic [31:0] regData
);
        logic [31:0] regs [16];

        // R0 is hardwired to zero on the read side.
        assign regData = (regSel == 4'd0) ? 32'd0 : regs[regSel];

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        for (int i = 0; i < 16; i++) begin
                                regs[i] <= 32'd0;
                        end
                end else if (regIn && regSel != 4'd0) begin
                        regs[regSel] <= busIn;
                end
        end

endmodule

//--- rtl/instrQueue.sv
`timescale 1ns/1ps
`include "busCpu_config.svh"

module instrQueue (
        input  logic              Clock,
        input  logic              rstN,
        input  logic              instrValid,
        input  isaPkg::instrWordT instrWord,
        input  logic              pop,
        output logic              queueEmpty,
        output isaPkg::instrWordT headWord,
        output logic              instrCredit
);
        import isaPkg::*;

        localparam int queueDepth = `BUSCPU_QUEUE_DEPTH;
        localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
        localparam int countWidth = $clog2(queueDepth + 1);
        localparam logic [ptrWidth-1:0] lastIdx = ptrWidth'(queueDepth - 1);

        instrWordT             mem [queueDepth];
        logic [ptrWidth-1:0]   wrPtr;
        logic [ptrWidth-1:0]   rdPtr;
        logic [countWidth-1:0] count;
        logic                  doPop;

        assign queueEmpty = (count == '0);
        assign headWord = mem[rdPtr];
        assign doPop = pop && !queueEmpty;      // The producer's credits keep pushes from overflowing.

        always_ff @(posedge Clock) begin
                if (instrValid) begin
                        mem[wrPtr] <= instrWord;
                end
        end

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                        instrCredit <= 1'b0;
                end else begin
                        if (instrValid) begin
                                wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
                        end
                        if (doPop) begin
                                rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
                        end
                        case ({instrValid, doPop})
                                2'b10: count <= count + 1'b1;
                                2'b01: count <= count - 1'b1;
                                default: count <= count;
                        endcase
                        instrCredit <= doPop;   // One freed slot gives back one credit.
                end
        end

endmodule

//--- rtl/datapathPkg.sv
package datapathPkg;

        // Which unit currently drives the shared bus.
        typedef enum logic [2:0] {
                srcNone = 3'd0,
                srcReg  = 3'd1,
                srcPc   = 3'd2,
                srcMdr  = 3'd3,
                srcZ    = 3'd4,
                srcImm  = 3'd5
        } busSrcT;

        typedef struct packed {
                logic           regOut;        // Drive enables, at most one high.
                logic           pcOut;
                logic           mdrOut;
                logic           zOut;
                logic           immOut;
                logic           mdrIn;
                logic           irIn;
                logic           yIn;
                logic           zIn;
                logic           regIn;
                logic           pcInc;
                logic [3:0]     regSel;
                isaPkg::opcodeT aluOp;
        } ctrlWordT;

        typedef struct packed {
                logic [3:0]  dest;
                logic [31:0] value;
                logic [3:0]  seq;      // Low PC bits at fetch.
        } resultT;

endpackage

//--- rtl/isaPkg.sv
package isaPkg;

        // Any opcode value not listed here is illegal and gets skipped.
        typedef enum logic [4:0] {
                opAdd  = 5'b00011,
                opSub  = 5'b00100,
                opShr  = 5'b00101,
                opShl  = 5'b00110,
                opAnd  = 5'b01001,
                opOr   = 5'b01010,
                opAddi = 5'b01011,
                opMul  = 5'b01110
        } opcodeT;

        typedef struct packed {
                opcodeT      opcode;
                logic [3:0]  ra;        // Destination.
                logic [3:0]  rb;
                logic [3:0]  rc;
                logic [14:0] unused;
        } rFormatT;

        typedef struct packed {
                opcodeT             opcode;
                logic [3:0]         ra;
                logic [3:0]         rb;
                logic signed [18:0] imm;
        } iFormatT;

        // The same instruction word seen through either format.
        typedef union packed {
                rFormatT rFmt;
                iFormatT iFmt;
        } instrWordT;

        function automatic logic isLegalOp(opcodeT op);
                case (op)
                        opAdd, opSub, opAnd, opOr, opShl, opShr, opMul, opAddi: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

endpackage

//--- include/busCpu_config.svh
`ifndef BUSCPU_CONFIG_SVH
`define BUSCPU_CONFIG_SVH

// Queue depth is also the number of instruction credits the producer starts with.
`define BUSCPU_QUEUE_DEPTH 4

// Result records the consumer can hold before it returns a credit.
`define BUSCPU_RESULT_CREDITS 2

`endif
